// ==== ks10Bus_config.svh ====
`ifndef KS10BUS_CONFIG_SVH
`define KS10BUS_CONFIG_SVH

////////////////////////////////////////
// Backplane word widths
////////////////////////////////////////

`define BUS_ADDR_WIDTH 36
`define BUS_DATA_WIDTH 36

// IO device select field width
`define IO_DEV_WIDTH 4
// Device number the responder answers to
`define IO_DEV_NUM 3
// Register and memory sizes
`define IO_REG_COUNT 4
`define MEM_WORDS 16

// Acknowledge latency in cycles after request
`define IO_ACK_DELAY 2
`define MEM_ACK_DELAY 1

// NXD timeout and recovery
`define NXD_TIMEOUT 6
`define NXD_HOLDOFF 2

`endif

// ==== ks10BusPkg.sv ====
`include "ks10Bus_config.svh"

package ks10BusPkg;

   ////////////////////////////////////////
   // Address word layout
   ////////////////////////////////////////

   // Function flags in the top five bits
   localparam int FlagWidth = 5;
   // IO register address field
   localparam int IoRegAddrWidth = 14;
   // Filler between flags and device number
   localparam int IoSpareWidth = `BUS_ADDR_WIDTH - FlagWidth - `IO_DEV_WIDTH - IoRegAddrWidth;
   // Memory word address after the flags
   localparam int MemAddrWidth = `BUS_ADDR_WIDTH - FlagWidth;

   // Same 36 bits, IO or memory decode
   typedef union packed {
      struct packed {
         logic                        io;
         logic                        wru;
         logic                        vect;
         logic                        read;
         logic                        write;
         logic [IoSpareWidth-1:0]     spare;
         logic [`IO_DEV_WIDTH-1:0]    dev;
         logic [IoRegAddrWidth-1:0]   regAddr;
      } ioView;
      struct packed {
         logic                        io;
         logic                        wru;
         logic                        vect;
         logic                        read;
         logic                        write;
         logic [MemAddrWidth-1:0]     wordAddr;
      } memView;
   } busAddrWord;

   // Control ROM special function select
   typedef enum logic [2:0] {
      SPEC_NONE     = 3'd0,
      SPEC_CLRIOLAT = 3'd5
   } specSel;

endpackage

// ==== nxd.sv ====
`timescale 1ns/1ps
`include "ks10Bus_config.svh"

module nxd
   import ks10BusPkg::*;
(
   input  logic       clk,
   input  logic       rst,
   input  logic       cromSpecEn,
   input  specSel     cromSpecSel,
   input  busAddrWord cpuAddr,
   input  logic       cpuReq,
   input  logic       cpuAck,
   output logic       ioWait,
   output logic       ioBusy
);

   // Counter wide enough for timeout and holdoff
   localparam int CntWidth = $clog2(`NXD_TIMEOUT + `NXD_HOLDOFF + 1);
   localparam logic [CntWidth-1:0] TimeoutCnt = CntWidth'(`NXD_TIMEOUT);
   localparam logic [CntWidth-1:0] HoldLast = CntWidth'(`NXD_HOLDOFF - 1);

   // Busy latch states
   localparam logic [1:0] busyIdle = 2'd0;
   localparam logic [1:0] busySet  = 2'd1;
   localparam logic [1:0] busyWait = 2'd2;

   // Timeout states
   localparam logic [1:0] timerIdle  = 2'd0;
   localparam logic [1:0] timerCount = 2'd1;
   localparam logic [1:0] timerHold  = 2'd2;

   logic                busIo;
   logic                busRead;
   logic                busWrite;
   logic                ioClear;
   logic [1:0]          busyState;
   logic [1:0]          timerState;
   logic [CntWidth-1:0] timerCnt;

   // Flag decode through the IO view
   assign busIo    = cpuAddr.ioView.io;
   assign busRead  = cpuAddr.ioView.read;
   assign busWrite = cpuAddr.ioView.write;

   // CLRIOLAT strobe from the control ROM
   assign ioClear = cromSpecEn && (cromSpecSel == SPEC_CLRIOLAT);

   ////////////////////////////////////////
   // IO busy latch
   ////////////////////////////////////////

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         busyState <= busyIdle;
      end
      else
      begin
         case (busyState)
            busyIdle:
               // IO read or write on the bus
               if (cpuReq && busIo && (busRead || busWrite))
                  busyState <= busySet;
            busySet:
               // Acknowledge or microcode clear
               if (cpuAck || ioClear)
                  busyState <= busyWait;
            busyWait:
               // Hold until the cycle is gone
               if (!(cpuReq && (busRead || busWrite)))
                  busyState <= busyIdle;
            default:
               busyState <= busyIdle;
         endcase
      end
   end

   assign ioBusy = (busyState == busySet);

   ////////////////////////////////////////
   // Timeout counter
   ////////////////////////////////////////

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         timerState <= timerIdle;
         timerCnt   <= '0;
      end
      else
      begin
         case (timerState)
            timerIdle:
               // First unanswered IO cycle counts as one
               if (cpuReq && busIo && !cpuAck)
               begin
                  timerState <= timerCount;
                  timerCnt   <= CntWidth'(1);
               end
            timerCount:
               if (!cpuReq || cpuAck || (timerCnt == TimeoutCnt))
               begin
                  timerState <= timerHold;
                  timerCnt   <= '0;
               end
               else
                  timerCnt <= timerCnt + 1'b1;
            timerHold:
               // Recovery before the next sequence
               if (timerCnt == HoldLast)
               begin
                  timerState <= timerIdle;
                  timerCnt   <= '0;
               end
               else
                  timerCnt <= timerCnt + 1'b1;
            default:
            begin
               timerState <= timerIdle;
               timerCnt   <= '0;
            end
         endcase
      end
   end

   // Stall the CPU until acknowledge or timeout
   assign ioWait = cpuReq && busIo && !cpuAck &&
                   ((timerState == timerIdle) ||
                    ((timerState == timerCount) && (timerCnt < TimeoutCnt)));

endmodule

// ==== ioSequencer.sv ====
`timescale 1ns/1ps
`include "ks10Bus_config.svh"

module ioSequencer
   import ks10BusPkg::*;
(
   input  logic                       clk,
   input  logic                       rst,
   input  logic                       cmdValid,
   input  busAddrWord                 cmdAddr,
   input  logic [`BUS_DATA_WIDTH-1:0] cmdData,
   input  logic                       ioWait,
   input  logic                       ioBusy,
   input  logic                       cpuAck,
   input  logic [`BUS_DATA_WIDTH-1:0] ackData,
   output logic                       cmdReady,
   output logic                       cpuReq,
   output busAddrWord                 cpuAddr,
   output logic [`BUS_DATA_WIDTH-1:0] cpuData,
   output logic                       cromSpecEn,
   output specSel                     cromSpecSel,
   output logic                       rspValid,
   output logic [`BUS_DATA_WIDTH-1:0] rspData,
   output logic                       rspPageFail
);

   // Holdoff count after a page fault
   localparam int HoldWidth = $clog2(`NXD_HOLDOFF + 1);
   localparam logic [HoldWidth-1:0] HoldLast = HoldWidth'(`NXD_HOLDOFF - 1);

   // Sequencer states
   localparam logic [1:0] seqIdle    = 2'd0;
   localparam logic [1:0] seqRequest = 2'd1;
   localparam logic [1:0] seqFinish  = 2'd2;
   localparam logic [1:0] seqHoldoff = 2'd3;

   logic [1:0]           state;
   logic [HoldWidth-1:0] holdCnt;
   logic                 cmdTake;
   logic                 xferEnd;
   logic                 pageFault;

   assign cmdTake = cmdValid && cmdReady;

   // End on acknowledge, or on ioWait falling for IO
   assign xferEnd = cpuAck || (cpuAddr.ioView.io && !ioWait);

   // Busy still set after the transaction
   assign pageFault = (state == seqFinish) && ioBusy;

   ////////////////////////////////////////
   // Control FSM
   ////////////////////////////////////////

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         state   <= seqIdle;
         holdCnt <= '0;
      end
      else
      begin
         case (state)
            seqIdle:
               if (cmdTake)
                  state <= seqRequest;
            seqRequest:
               // Keep requesting through the stall
               if (xferEnd)
                  state <= seqFinish;
            seqFinish:
               // Fault gets extra recovery time
               if (ioBusy)
               begin
                  state   <= seqHoldoff;
                  holdCnt <= '0;
               end
               else
                  state <= seqIdle;
            seqHoldoff:
               if (holdCnt == HoldLast)
                  state <= seqIdle;
               else
                  holdCnt <= holdCnt + 1'b1;
            default:
               state <= seqIdle;
         endcase
      end
   end

   ////////////////////////////////////////
   // Command and response data
   ////////////////////////////////////////

   always_ff @(posedge clk)
   begin
      if (cmdTake)
      begin
         cpuAddr <= cmdAddr;
         cpuData <= cmdData;
         // Faulted cycles return zero
         rspData <= '0;
      end
      else if ((state == seqRequest) && cpuAck)
         rspData <= ackData;
   end

   assign cmdReady = (state == seqIdle);
   assign cpuReq   = (state == seqRequest);
   assign rspValid = (state == seqFinish);

   // Page fault report and IO latch clear
   assign rspPageFail = pageFault;
   assign cromSpecEn  = pageFault;
   assign cromSpecSel = pageFault ? SPEC_CLRIOLAT : SPEC_NONE;

endmodule

// ==== backplaneResponder.sv ====
`timescale 1ns/1ps
`include "ks10Bus_config.svh"

module backplaneResponder
   import ks10BusPkg::*;
(
   input  logic                       clk,
   input  logic                       rst,
   input  logic                       cpuReq,
   input  busAddrWord                 cpuAddr,
   input  logic [`BUS_DATA_WIDTH-1:0] cpuData,
   output logic                       cpuAck,
   output logic [`BUS_DATA_WIDTH-1:0] ackData
);

   localparam int RegIdxWidth = $clog2(`IO_REG_COUNT);
   localparam int MemIdxWidth = $clog2(`MEM_WORDS);
   // Delay counter sized for the slower path
   localparam int MaxDelay = (`IO_ACK_DELAY > `MEM_ACK_DELAY) ? `IO_ACK_DELAY : `MEM_ACK_DELAY;
   localparam int DlyWidth = $clog2(MaxDelay + 1);

   logic [`BUS_DATA_WIDTH-1:0] ioRegs [`IO_REG_COUNT];
   logic [`BUS_DATA_WIDTH-1:0] memWords [`MEM_WORDS];

   logic                   isIo;
   logic                   devHit;
   logic                   answer;
   logic                   wrFlag;
   logic [RegIdxWidth-1:0] regIdx;
   logic [MemIdxWidth-1:0] memIdx;
   logic [DlyWidth-1:0]    ackDelay;
   logic [DlyWidth-1:0]    delayCnt;
   logic                   acked;
   logic                   ackFire;
   logic [`BUS_DATA_WIDTH-1:0] rdData;

   ////////////////////////////////////////
   // Address decode
   ////////////////////////////////////////

   assign isIo   = cpuAddr.ioView.io;
   assign devHit = (cpuAddr.ioView.dev == `IO_DEV_WIDTH'(`IO_DEV_NUM));
   assign regIdx = cpuAddr.ioView.regAddr[RegIdxWidth-1:0];
   assign memIdx = cpuAddr.memView.wordAddr[MemIdxWidth-1:0];

   // Other IO devices stay silent so NXD times out
   assign answer = isIo ? (devHit && (cpuAddr.ioView.read || cpuAddr.ioView.write)) : 1'b1;
   // Write flag sits in the same bit for both views
   assign wrFlag = cpuAddr.ioView.write;

   // Last count before acknowledge
   assign ackDelay = isIo ? DlyWidth'(`IO_ACK_DELAY - 1) : DlyWidth'(`MEM_ACK_DELAY - 1);
   assign ackFire  = cpuReq && answer && !acked && (delayCnt == ackDelay);

   assign rdData = isIo ? ioRegs[regIdx] : memWords[memIdx];

   // Per-transaction acknowledge timing
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         cpuAck   <= 1'b0;
         acked    <= 1'b0;
         delayCnt <= '0;
      end
      else
      begin
         // Single pulse per request
         cpuAck <= ackFire;
         if (!cpuReq)
         begin
            acked    <= 1'b0;
            delayCnt <= '0;
         end
         else if (ackFire)
            acked <= 1'b1;
         else if (answer && !acked)
            delayCnt <= delayCnt + 1'b1;
      end
   end

   // Storage update and read data with the acknowledge
   always_ff @(posedge clk)
   begin
      if (ackFire)
      begin
         ackData <= rdData;
         if (wrFlag && isIo)
            ioRegs[regIdx] <= cpuData;
         else if (wrFlag)
            memWords[memIdx] <= cpuData;
      end
   end

endmodule

// ==== ks10IoBus.sv ====
`timescale 1ns/1ps
`include "ks10Bus_config.svh"

module ks10IoBus
   import ks10BusPkg::*;
(
   input  logic                       clk,
   input  logic                       rst,
   input  logic                       cmdValid,
   input  busAddrWord                 cmdAddr,
   input  logic [`BUS_DATA_WIDTH-1:0] cmdData,
   output logic                       cmdReady,
   output logic                       rspValid,
   output logic [`BUS_DATA_WIDTH-1:0] rspData,
   output logic                       rspPageFail
);

   ////////////////////////////////////////
   // Backplane bus signals
   ////////////////////////////////////////

   logic                       cpuReq;
   busAddrWord                 cpuAddr;
   logic [`BUS_DATA_WIDTH-1:0] cpuData;
   logic                       cpuAck;
   logic [`BUS_DATA_WIDTH-1:0] ackData;
   // Control ROM special function strobe
   logic                       cromSpecEn;
   specSel                     cromSpecSel;
   // NXD status into the sequencer
   logic                       ioWait;
   logic                       ioBusy;

   // Microcode stand-in
   ioSequencer seqInst (
      .clk(clk), .rst(rst), .cmdValid(cmdValid), .cmdAddr(cmdAddr), .cmdData(cmdData),
      .ioWait(ioWait), .ioBusy(ioBusy), .cpuAck(cpuAck), .ackData(ackData),
      .cmdReady(cmdReady), .cpuReq(cpuReq), .cpuAddr(cpuAddr), .cpuData(cpuData),
      .cromSpecEn(cromSpecEn), .cromSpecSel(cromSpecSel), .rspValid(rspValid),
      .rspData(rspData), .rspPageFail(rspPageFail));

   // Device timeout and IO busy latch
   nxd nxdInst (
      .clk(clk), .rst(rst), .cromSpecEn(cromSpecEn), .cromSpecSel(cromSpecSel),
      .cpuAddr(cpuAddr), .cpuReq(cpuReq), .cpuAck(cpuAck),
      .ioWait(ioWait), .ioBusy(ioBusy));

   // IO device and memory on the backplane
   backplaneResponder responderInst (
      .clk(clk), .rst(rst), .cpuReq(cpuReq), .cpuAddr(cpuAddr), .cpuData(cpuData),
      .cpuAck(cpuAck), .ackData(ackData));

endmodule

// ==== tbKs10IoBus.sv ====
`timescale 1ns/1ps
`include "ks10Bus_config.svh"

module tbKs10IoBus
   import ks10BusPkg::*;
();

   localparam logic [31:0] LfsrSeed = 32'ha790_7e14;
   localparam logic [`IO_DEV_WIDTH-1:0] GoodDev = `IO_DEV_WIDTH'(`IO_DEV_NUM);
   localparam int RegBits = $clog2(`IO_REG_COUNT);
   localparam int MemBits = $clog2(`MEM_WORDS);
   // Directed writes, read-backs, then fault and recovery pairs
   localparam int NumDirected = 4 * `IO_REG_COUNT + 2 * `MEM_WORDS;
   localparam int NumRandom = 40;
   localparam int NumCmds = NumDirected + NumRandom;
   // Worst case is a fault plus holdoff per command
   localparam int TimeoutCycles = NumCmds * (`NXD_TIMEOUT + 8) + 100;

   logic                       clk;
   logic                       rst;
   logic                       cmdValid;
   busAddrWord                 cmdAddr;
   logic [`BUS_DATA_WIDTH-1:0] cmdData;
   logic                       cmdReady;
   logic                       rspValid;
   logic [`BUS_DATA_WIDTH-1:0] rspData;
   logic                       rspPageFail;

   // Scoreboard model of the device registers and memory
   logic [`BUS_DATA_WIDTH-1:0] regModel [`IO_REG_COUNT];
   logic [`BUS_DATA_WIDTH-1:0] memModel [`MEM_WORDS];

   // Expected result of the command in flight
   int                         expLat;
   logic                       expFault;
   logic                       expRead;
   logic [`BUS_DATA_WIDTH-1:0] expData;

   // Monitor state
   logic       inFlight;
   int         sinceTake;
   logic       waiting;
   int         waitCnt;
   logic       waitFault;
   int         cmdCount;
   int         respCount;
   int         errCount = 0;
   int         cycleCount;
   logic [31:0] lfsrState;

   ks10IoBus ks10IoBus_inst (
      .clk(clk), .rst(rst), .cmdValid(cmdValid), .cmdAddr(cmdAddr), .cmdData(cmdData),
      .cmdReady(cmdReady), .rspValid(rspValid), .rspData(rspData),
      .rspPageFail(rspPageFail));

   initial
   begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // Fibonacci LFSR, x^32 + x^22 + x^2 + x + 1, one step per bit
   function automatic logic [`BUS_DATA_WIDTH-1:0] randBits(input int n);
      logic [`BUS_DATA_WIDTH-1:0] val;
      logic                       fb;
      val = '0;
      for (int i = 0; i < n; i++)
      begin
         fb = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
         lfsrState = {lfsrState[30:0], fb};
         val = {val[`BUS_DATA_WIDTH-2:0], fb};
      end
      return val;
   endfunction

   ////////////////////////////////////////
   // Command driver
   ////////////////////////////////////////

   task automatic sendCommand(input logic isIo, input logic isWrite,
                              input logic [`IO_DEV_WIDTH-1:0] dev, input int idx,
                              input logic [`BUS_DATA_WIDTH-1:0] data,
                              input logic keepValid);
      busAddrWord                 addr;
      logic                       fault;
      int                         lat;
      logic [`BUS_DATA_WIDTH-1:0] predicted;
      addr = '0;
      fault = 1'b0;
      predicted = '0;
      if (isIo)
      begin
         addr.ioView.io      = 1'b1;
         addr.ioView.read    = !isWrite;
         addr.ioView.write   = isWrite;
         addr.ioView.dev     = dev;
         addr.ioView.regAddr = IoRegAddrWidth'(idx);
         // Unknown device is never acknowledged
         fault = (dev != GoodDev);
         // Take, request, ack delay, end, response
         lat = fault ? `NXD_TIMEOUT + 2 : `IO_ACK_DELAY + 2;
         if (!fault && isWrite)
            regModel[idx] = data;
         else if (!fault)
            predicted = regModel[idx];
      end
      else
      begin
         addr.memView.read     = !isWrite;
         addr.memView.write    = isWrite;
         addr.memView.wordAddr = MemAddrWidth'(idx);
         lat = `MEM_ACK_DELAY + 2;
         if (isWrite)
            memModel[idx] = data;
         else
            predicted = memModel[idx];
      end
      cmdAddr  <= addr;
      cmdData  <= data;
      cmdValid <= 1'b1;
      @(posedge clk);
      while (!cmdReady)
         @(posedge clk);
      // Taken on this edge
      expLat   <= lat;
      expFault <= fault;
      expRead  <= !isWrite;
      expData  <= predicted;
      if (!keepValid)
         cmdValid <= 1'b0;
   endtask

   task automatic waitResponse();
      @(posedge clk);
      while (!rspValid)
         @(posedge clk);
   endtask

   // Random pick of good IO, memory or a missing device
   task automatic randomCommand(input logic keepValid);
      logic [1:0]                 kind;
      logic                       wr;
      logic [`IO_DEV_WIDTH-1:0]   dev;
      logic [`BUS_DATA_WIDTH-1:0] data;
      kind = 2'(randBits(2));
      wr   = randBits(1) != 0;
      data = randBits(`BUS_DATA_WIDTH);
      dev  = `IO_DEV_WIDTH'(randBits(`IO_DEV_WIDTH));
      if (dev == GoodDev)
         dev = dev ^ `IO_DEV_WIDTH'(1);
      case (kind)
         2'd0: sendCommand(1'b1, wr, GoodDev, int'(randBits(RegBits)), data, keepValid);
         2'd2: sendCommand(1'b1, wr, dev, int'(randBits(RegBits)), data, keepValid);
         default: sendCommand(1'b0, wr, '0, int'(randBits(MemBits)), data, keepValid);
      endcase
   endtask

   ////////////////////////////////////////
   // Monitor
   ////////////////////////////////////////

   always @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         inFlight  <= 1'b0;
         sinceTake <= 0;
         waiting   <= 1'b0;
         waitCnt   <= 0;
         waitFault <= 1'b0;
         cmdCount  <= 0;
         respCount <= 0;
      end
      else
      begin
         if (cmdValid && cmdReady)
         begin
            inFlight  <= 1'b1;
            sinceTake <= 1;
            cmdCount  <= cmdCount + 1;
         end
         else if (inFlight)
            sinceTake <= sinceTake + 1;
         // Cycles from response until cmdReady is back
         if (rspValid)
         begin
            inFlight  <= 1'b0;
            respCount <= respCount + 1;
            waiting   <= 1'b1;
            waitCnt   <= 1;
            waitFault <= rspPageFail;
         end
         else if (waiting && cmdReady)
            waiting <= 1'b0;
         else if (waiting)
            waitCnt <= waitCnt + 1;
      end
   end

   ////////////////////////////////////////
   // Checks
   ////////////////////////////////////////

   checkResetReady: assert property (@(posedge clk) $fell(rst) |-> cmdReady)
      else begin errCount++; $display("FAILED at %0t: cmdReady got 0 expected 1", $time); end
   checkResetRsp: assert property (@(posedge clk) $fell(rst) |-> !rspValid)
      else begin errCount++; $display("FAILED at %0t: rspValid got 1 expected 0", $time); end
   checkTaken: assert property (@(posedge clk) disable iff (rst) rspValid |-> inFlight)
      else begin errCount++; $display("ERROR at %0t: response with no command taken", $time); end
   checkPulse: assert property (@(posedge clk) disable iff (rst) rspValid |=> !rspValid)
      else begin errCount++; $display("ERROR at %0t: rspValid longer than one cycle", $time); end
   checkBusy: assert property (@(posedge clk) disable iff (rst) inFlight |-> !cmdReady)
      else begin errCount++; $display("FAILED at %0t: cmdReady got 1 expected 0", $time); end
   checkLatency: assert property (@(posedge clk) disable iff (rst)
                                  rspValid |-> sinceTake == expLat)
      else begin
         errCount++;
         $display("FAILED at %0t: rspValid latency got %0d expected %0d", $time,
                  $sampled(sinceTake), $sampled(expLat));
      end
   checkFault: assert property (@(posedge clk) disable iff (rst)
                                rspValid |-> rspPageFail == expFault)
      else begin
         errCount++;
         $display("FAILED at %0t: rspPageFail got %b expected %b", $time,
                  $sampled(rspPageFail), $sampled(expFault));
      end
   checkData: assert property (@(posedge clk) disable iff (rst)
                               rspValid && expRead && !expFault |-> rspData == expData)
      else begin
         errCount++;
         $display("FAILED at %0t: rspData got %h expected %h", $time,
                  $sampled(rspData), $sampled(expData));
      end
   // Holdoff adds to the normal one-cycle return after a fault
   checkReady: assert property (@(posedge clk) disable iff (rst)
                                waiting |-> cmdReady ==
                                (waitCnt >= (waitFault ? 1 + `NXD_HOLDOFF : 1)))
      else begin
         errCount++;
         $display("FAILED at %0t: cmdReady got %b expected %b", $time, $sampled(cmdReady),
                  !$sampled(cmdReady));
      end

   ////////////////////////////////////////
   // Stimulus
   ////////////////////////////////////////

   initial
   begin
      rst = 1'b1;
      cmdValid = 1'b0;
      cmdAddr = '0;
      cmdData = '0;
      lfsrState = LfsrSeed;
      repeat (3) @(posedge clk);
      rst <= 1'b0;
      @(posedge clk);
      // IO registers, fill then random read-back
      for (int i = 0; i < `IO_REG_COUNT; i++)
      begin
         sendCommand(1'b1, 1'b1, GoodDev, i, randBits(`BUS_DATA_WIDTH), 1'b0);
         waitResponse();
      end
      for (int i = 0; i < `IO_REG_COUNT; i++)
      begin
         sendCommand(1'b1, 1'b0, GoodDev, int'(randBits(RegBits)), '0, 1'b0);
         waitResponse();
      end
      // Memory words
      for (int i = 0; i < `MEM_WORDS; i++)
      begin
         sendCommand(1'b0, 1'b1, '0, i, randBits(`BUS_DATA_WIDTH), 1'b0);
         waitResponse();
      end
      for (int i = 0; i < `MEM_WORDS; i++)
      begin
         sendCommand(1'b0, 1'b0, '0, int'(randBits(MemBits)), '0, 1'b0);
         waitResponse();
      end
      // Faulted write, then the same register must be unchanged
      for (int i = 0; i < `IO_REG_COUNT; i++)
      begin
         sendCommand(1'b1, 1'b1, GoodDev ^ `IO_DEV_WIDTH'(i + 1), i,
                     randBits(`BUS_DATA_WIDTH), 1'b0);
         waitResponse();
         sendCommand(1'b1, 1'b0, GoodDev, i, '0, 1'b0);
         waitResponse();
      end
      // Back to back with cmdValid held high
      for (int n = 0; n < NumRandom; n++)
         randomCommand(n != NumRandom - 1);
      waitResponse();
      repeat (4) @(posedge clk);
      if (cmdCount != NumCmds || respCount != cmdCount)
      begin
         errCount++;
         $display("ERROR: %0d commands issued, %0d taken, %0d responses",
                  NumCmds, cmdCount, respCount);
      end
      $display("Summary: %0d commands, %0d responses, %0d errors",
               cmdCount, respCount, errCount);
      if (errCount == 0)
         $display("PASS: all tests");
      else
         $display("FAIL: see errors above");
      $finish;
   end

   // Run limit
   initial
   begin
      cycleCount = 0;
      while (cycleCount < TimeoutCycles)
      begin
         @(posedge clk);
         cycleCount++;
      end
      $display("ERROR: run did not finish within %0d cycles", TimeoutCycles);
      $display("Summary: %0d commands, %0d responses, %0d errors",
               cmdCount, respCount, errCount);
      $display("FAIL: see errors above");
      $finish;
   end

endmodule

// ==== tb.f ====
+incdir+.
ks10BusPkg.sv
nxd.sv
ioSequencer.sv
backplaneResponder.sv
ks10IoBus.sv
tbKs10IoBus.sv
